/* src/spritePkg.sv */
// Sprite engine shared definitions
// Widths, register map constants and the slot register word layout
`default_nettype none

package spritePkg;

    //----------------------------------------------------------------------
    // Widths
    //----------------------------------------------------------------------
    localparam int coordWidth     = 8;    // Pixel coordinate
    localparam int colorWidth     = 4;    // Colour index, 0 is transparent
    localparam int sheetAddrWidth = 12;   // 4096 sheet entries
    localparam int regWordWidth   = 32;
    localparam int hostAddrWidth  = 13;   // Top bit selects sheet memory

    //----------------------------------------------------------------------
    // Register map
    //----------------------------------------------------------------------
    localparam int maxSlots  = 8;
    localparam int bgRegAddr = 2 * maxSlots;   // Sits right after the last slot pair

    // Even address holds the attribute view, odd address the position view
    typedef union packed {
        struct packed {
            logic [sheetAddrWidth-1:0] sheetOffset;   // Base of the image in the sheet
            logic [5:0]                imgWidth;
            logic [5:0]                imgHeight;
            logic [6:0]                sheetStride;   // Sheet entries per image row
            logic                      mirror;        // Flip horizontally
        } attrView;
        struct packed {
            logic [coordWidth-1:0] posX;
            logic [coordWidth-1:0] posY;
            logic [14:0]           reserved;
            logic                  enable;
        } posView;
    } slotWord_u;

endpackage

`default_nettype wire

/* src/spriteMemory.sv */
// Sprite sheet memory
// 4096 colour indices, one port, synchronous write and registered read
`timescale 1ns/10ps
`default_nettype none

module spriteMemory (
    input  logic                                  Clk,
    input  logic                                  we,
    input  logic [spritePkg::sheetAddrWidth-1:0]  addr,
    input  logic [spritePkg::colorWidth-1:0]      wrData,
    output logic [spritePkg::colorWidth-1:0]      rdData
);

    localparam int Depth = 1 << spritePkg::sheetAddrWidth;

    logic [spritePkg::colorWidth-1:0] mem [Depth];

    //----------------------------------------------------------------------
    // Single port, read returns the old word on a write cycle
    //----------------------------------------------------------------------
    always_ff @(posedge Clk) begin
        if (we) begin
            mem[addr] <= wrData;
        end
        rdData <= mem[addr];   // Valid the cycle after the address
    end

endmodule

`default_nettype wire

/* src/spriteLayer.sv */
// Sprite layer for one slot
// Tests the current pixel against the slot, computes the sheet address,
// requests the fetch and holds the returned colour
`timescale 1ns/10ps
`default_nettype none

module spriteLayer (
    input  logic                                  Clk,
    input  logic                                  rstN,
    input  logic                                  start,
    input  logic [spritePkg::coordWidth-1:0]      curX,
    input  logic [spritePkg::coordWidth-1:0]      curY,
    input  spritePkg::slotWord_u                  attr,
    input  spritePkg::slotWord_u                  pos,
    output logic                                  fetchValid,
    output logic [spritePkg::sheetAddrWidth-1:0]  fetchAddr,
    input  logic                                  fetchDone,
    input  logic [spritePkg::colorWidth-1:0]      rdData,
    output logic                                  layerDone,
    output logic [spritePkg::colorWidth-1:0]      layerColor
);

    logic [spritePkg::coordWidth:0]       xEnd;      // Extra bit so the edge cannot wrap
    logic [spritePkg::coordWidth:0]       yEnd;
    logic                                 hit;
    logic                                 pending;   // Fetch still outstanding
    logic [5:0]                           colRaw;
    logic [5:0]                           col;
    logic [5:0]                           row;
    logic [spritePkg::sheetAddrWidth-1:0] rowBase;

    // Hit test
    assign xEnd = pos.posView.posX + attr.attrView.imgWidth;
    assign yEnd = pos.posView.posY + attr.attrView.imgHeight;
    assign hit  = pos.posView.enable &&
                  (curX >= pos.posView.posX) && (curX < xEnd) &&
                  (curY >= pos.posView.posY) && (curY < yEnd);

    // Sheet address, wraps at 12 bits
    assign colRaw    = 6'(curX - pos.posView.posX);
    assign col       = attr.attrView.mirror ? attr.attrView.imgWidth - 6'd1 - colRaw : colRaw;
    assign row       = 6'(curY - pos.posView.posY);
    assign rowBase   = row * attr.attrView.sheetStride;
    assign fetchAddr = attr.attrView.sheetOffset + rowBase + col;

    assign fetchValid = pending || (start && hit);   // Can be granted in the start cycle

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            pending   <= 1'b0;
            layerDone <= 1'b0;
        end else if (start) begin
            pending   <= hit;
            layerDone <= !hit;   // No hit means done next cycle
        end else if (fetchDone) begin
            pending   <= 1'b0;
            layerDone <= 1'b1;
        end
    end

    always_ff @(posedge Clk) begin
        if (start) begin
            layerColor <= '0;   // Transparent unless a fetch returns
        end else if (fetchDone) begin
            layerColor <= rdData;
        end
    end

endmodule

`default_nettype wire

/* src/fetchArbiter.sv */
// Fetch arbiter
// Round-robin over the sprite slots and the host, one grant per cycle.
// Slot grants read the sheet memory, the host grant writes it
`timescale 1ns/10ps
`default_nettype none

module fetchArbiter #(
    parameter int NumSlots = 4
) (
    input  logic                                  Clk,
    input  logic                                  rstN,
    input  logic [NumSlots-1:0]                   fetchValid,
    input  logic [spritePkg::sheetAddrWidth-1:0]  fetchAddr [NumSlots],
    output logic [NumSlots-1:0]                   fetchDone,
    input  logic                                  memWrValid,
    input  logic [spritePkg::sheetAddrWidth-1:0]  memWrAddr,
    input  logic [spritePkg::colorWidth-1:0]      memWrData,
    output logic                                  memWrGrant,
    output logic [spritePkg::colorWidth-1:0]      rdData
);

    localparam int NumReq   = NumSlots + 1;   // Host is the last requester
    localparam int PtrWidth = $clog2(NumReq);

    logic [NumReq-1:0]                    req;
    logic [NumReq-1:0]                    grant;
    logic [PtrWidth-1:0]                  ptr;
    logic [PtrWidth-1:0]                  nextPtr;
    logic [spritePkg::sheetAddrWidth-1:0] memAddr;

    // A slot whose read is returning this cycle still shows fetchValid, skip it
    assign req        = {memWrValid, fetchValid & ~fetchDone};
    assign memWrGrant = grant[NumSlots];

    //----------------------------------------------------------------------
    // Round-robin pick starting at ptr
    //----------------------------------------------------------------------
    always_comb begin
        int   idx;
        logic found;
        grant   = '0;
        nextPtr = ptr;
        found   = 1'b0;
        for (int k = 0; k < NumReq; k++) begin
            idx = int'(ptr) + k;
            if (idx >= NumReq) idx = idx - NumReq;
            if (!found && req[idx]) begin
                grant[idx] = 1'b1;
                nextPtr    = (idx == NumReq - 1) ? '0 : PtrWidth'(idx + 1);
                found      = 1'b1;
            end
        end
    end

    always_comb begin
        memAddr = memWrAddr;
        for (int i = 0; i < NumSlots; i++) begin
            if (grant[i]) memAddr = fetchAddr[i];
        end
    end

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            ptr       <= '0;
            fetchDone <= '0;
        end else begin
            ptr       <= nextPtr;
            fetchDone <= grant[NumSlots-1:0];   // Read data lands one cycle later
        end
    end

    spriteMemory sheetMem (
        .Clk    (Clk),
        .we     (memWrGrant),
        .addr   (memAddr),
        .wrData (memWrData),
        .rdData (rdData)
    );

    assert property (@(posedge Clk) disable iff (!rstN) $onehot0(grant));

endmodule

`default_nettype wire

/* src/hostPort.sv */
// Host write port
// Stores slot and background register words, forwards sheet writes
// to the fetch arbiter as a held request
`timescale 1ns/10ps
`default_nettype none

module hostPort #(
    parameter int NumSlots = 4
) (
    input  logic                                  Clk,
    input  logic                                  rstN,
    input  logic                                  hostValid,
    input  logic [spritePkg::hostAddrWidth-1:0]   hostAddr,
    input  logic [spritePkg::regWordWidth-1:0]    hostData,
    output logic                                  hostReady,
    output logic                                  memWrValid,
    input  logic                                  memWrGrant,
    output logic [spritePkg::sheetAddrWidth-1:0]  memWrAddr,
    output logic [spritePkg::colorWidth-1:0]      memWrData,
    output spritePkg::slotWord_u                  slotAttr [NumSlots],
    output spritePkg::slotWord_u                  slotPos [NumSlots],
    output logic [spritePkg::colorWidth-1:0]      bgColor
);

    logic                                 memSel;
    logic                                 regWr;
    logic [spritePkg::sheetAddrWidth-1:0] regAddr;

    assign memSel    = hostAddr[spritePkg::hostAddrWidth-1];
    assign regWr     = hostValid && !memSel;
    assign regAddr   = hostAddr[spritePkg::sheetAddrWidth-1:0];
    assign hostReady = memSel ? memWrGrant : 1'b1;   // Register writes never wait
    assign memWrAddr = regAddr;
    assign memWrData = hostData[spritePkg::colorWidth-1:0];

    //----------------------------------------------------------------------
    // Sheet write request, held until the arbiter grants it
    //----------------------------------------------------------------------
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            memWrValid <= 1'b0;
        end else if (memWrValid) begin
            memWrValid <= !memWrGrant;
        end else begin
            memWrValid <= hostValid && memSel;
        end
    end

    //----------------------------------------------------------------------
    // Register words
    //----------------------------------------------------------------------
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            for (int i = 0; i < NumSlots; i++) begin
                slotAttr[i] <= '0;
                slotPos[i]  <= '0;
            end
            bgColor <= '0;
        end else if (regWr) begin
            for (int i = 0; i < NumSlots; i++) begin
                if (regAddr == 2 * i) slotAttr[i] <= hostData;
                if (regAddr == 2 * i + 1) slotPos[i] <= hostData;
            end
            if (regAddr == spritePkg::bgRegAddr) begin
                bgColor <= hostData[spritePkg::colorWidth-1:0];
            end
        end
    end

    // Host must keep the sheet address on the bus while the request waits
    assert property (@(posedge Clk) disable iff (!rstN)
        memWrValid |-> hostValid && hostAddr[spritePkg::hostAddrWidth-1]);

endmodule

`default_nettype wire

/* src/pixelCompositor.sv */
// Pixel compositor
// Accepts one pixel request at a time, broadcasts it to the layers,
// then returns the lowest-numbered opaque colour or the background
`timescale 1ns/10ps
`default_nettype none

module pixelCompositor #(
    parameter int NumSlots = 4
) (
    input  logic                              Clk,
    input  logic                              rstN,
    input  logic                              pixValid,
    output logic                              pixReady,
    input  logic [spritePkg::coordWidth-1:0]  pixX,
    input  logic [spritePkg::coordWidth-1:0]  pixY,
    output logic                              start,
    output logic [spritePkg::coordWidth-1:0]  curX,
    output logic [spritePkg::coordWidth-1:0]  curY,
    input  logic [NumSlots-1:0]               layerDone,
    input  logic [spritePkg::colorWidth-1:0]  layerColor [NumSlots],
    input  logic [spritePkg::colorWidth-1:0]  bgColor,
    output logic                              pixOutValid,
    output logic [spritePkg::colorWidth-1:0]  pixOutColor,
    input  logic                              pixOutReady
);

    localparam logic [1:0] stIdle    = 2'd0;
    localparam logic [1:0] stBusy    = 2'd1;   // Start cycle, layers see the pixel
    localparam logic [1:0] stRespond = 2'd2;   // Wait for layers, then present

    logic [1:0] state;

    assign pixReady    = (state == stIdle);
    assign start       = (state == stBusy);
    assign pixOutValid = (state == stRespond) && (&layerDone);

    //----------------------------------------------------------------------
    // Handshake FSM
    //----------------------------------------------------------------------
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            state <= stIdle;
        end else begin
            case (state)
                stIdle:    if (pixValid) state <= stBusy;
                stBusy:    state <= stRespond;
                stRespond: if (pixOutValid && pixOutReady) state <= stIdle;
                default:   state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (pixValid && pixReady) begin
            curX <= pixX;
            curY <= pixY;
        end
    end

    // Lowest slot with a nonzero colour wins
    always_comb begin
        pixOutColor = bgColor;
        for (int i = NumSlots - 1; i >= 0; i--) begin
            if (layerColor[i] != '0) pixOutColor = layerColor[i];
        end
    end

    assert property (@(posedge Clk) disable iff (!rstN)
        pixOutValid && !pixOutReady |=> pixOutValid && $stable(pixOutColor));

endmodule

`default_nettype wire

/* src/spriteEngine.sv */
// Sprite engine top level
// Host register and sheet port, one layer per slot, shared fetch
// arbiter with the sheet memory, and the pixel compositor
`timescale 1ns/10ps
`default_nettype none

module spriteEngine #(
    parameter int NumSlots = 4   // 1 to maxSlots
) (
    input  logic                                 Clk,
    input  logic                                 rstN,
    input  logic                                 hostValid,
    input  logic [spritePkg::hostAddrWidth-1:0]  hostAddr,
    input  logic [spritePkg::regWordWidth-1:0]   hostData,
    output logic                                 hostReady,
    input  logic                                 pixValid,
    input  logic [spritePkg::coordWidth-1:0]     pixX,
    input  logic [spritePkg::coordWidth-1:0]     pixY,
    output logic                                 pixReady,
    output logic                                 pixOutValid,
    output logic [spritePkg::colorWidth-1:0]     pixOutColor,
    input  logic                                 pixOutReady
);

    spritePkg::slotWord_u                 slotAttr [NumSlots];
    spritePkg::slotWord_u                 slotPos [NumSlots];
    logic [spritePkg::colorWidth-1:0]     bgColor;
    logic                                 memWrValid;
    logic                                 memWrGrant;
    logic [spritePkg::sheetAddrWidth-1:0] memWrAddr;
    logic [spritePkg::colorWidth-1:0]     memWrData;
    logic                                 start;
    logic [spritePkg::coordWidth-1:0]     curX;
    logic [spritePkg::coordWidth-1:0]     curY;
    logic [NumSlots-1:0]                  fetchValid;
    logic [spritePkg::sheetAddrWidth-1:0] fetchAddr [NumSlots];
    logic [NumSlots-1:0]                  fetchDone;
    logic [spritePkg::colorWidth-1:0]     rdData;
    logic [NumSlots-1:0]                  layerDone;
    logic [spritePkg::colorWidth-1:0]     layerColor [NumSlots];

    hostPort #(.NumSlots(NumSlots)) host (
        .Clk, .rstN, .hostValid, .hostAddr, .hostData, .hostReady,
        .memWrValid, .memWrGrant, .memWrAddr, .memWrData,
        .slotAttr, .slotPos, .bgColor
    );

    //----------------------------------------------------------------------
    // One layer per slot
    //----------------------------------------------------------------------
    for (genvar i = 0; i < NumSlots; i++) begin : genLayer
        spriteLayer layer (
            .Clk        (Clk),
            .rstN       (rstN),
            .start      (start),
            .curX       (curX),
            .curY       (curY),
            .attr       (slotAttr[i]),
            .pos        (slotPos[i]),
            .fetchValid (fetchValid[i]),
            .fetchAddr  (fetchAddr[i]),
            .fetchDone  (fetchDone[i]),
            .rdData     (rdData),
            .layerDone  (layerDone[i]),
            .layerColor (layerColor[i])
        );
    end

    fetchArbiter #(.NumSlots(NumSlots)) arbiter (
        .Clk, .rstN, .fetchValid, .fetchAddr, .fetchDone,
        .memWrValid, .memWrAddr, .memWrData, .memWrGrant, .rdData
    );

    pixelCompositor #(.NumSlots(NumSlots)) compositor (
        .Clk, .rstN, .pixValid, .pixReady, .pixX, .pixY,
        .start, .curX, .curY, .layerDone, .layerColor, .bgColor,
        .pixOutValid, .pixOutColor, .pixOutReady
    );

endmodule

`default_nettype wire

/* verification/spriteChecker.sv */
// Sprite engine response checker
// Loads the expected pixel colours from the test file and compares
// each completed pixel response with the next one in order
`timescale 1ns/10ps
`default_nettype none

module spriteChecker (
    input  logic                             Clk,
    input  logic                             rstN,
    input  logic                             pixOutValid,
    input  logic [spritePkg::colorWidth-1:0] pixOutColor,
    input  logic                             pixOutReady,
    output int                               checkedCount,
    output int                               errorCount,
    output int                               testCount
);

    localparam int MaxTests = 64;

    string                            testNames [MaxTests];
    logic [spritePkg::colorWidth-1:0] expColors [MaxTests];

    initial begin
        int    fd;
        int    code;
        int    x;
        int    y;
        string line;
        checkedCount = 0;
        errorCount   = 0;
        testCount    = 0;
        fd = $fopen("verification/spriteTests.txt", "r");
        if (fd == 0) begin
            $display("Checker cannot open the test file");
            errorCount++;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0 && line.getc(0) == "P" && testCount < MaxTests) begin
                    code = $sscanf(line, "P %s %d %d %h", testNames[testCount], x, y,
                                   expColors[testCount]);
                    testCount++;
                end
            end
            $fclose(fd);
        end
    end

    // A response counts on the edge where valid and ready are both high
    always @(posedge Clk) begin
        if (rstN && pixOutValid && pixOutReady) begin
            if (checkedCount >= testCount) begin
                $display("Pixel response with colour %0h arrived after the last test",
                         pixOutColor);
                errorCount++;
            end else if (pixOutColor !== expColors[checkedCount]) begin
                $display("ERROR %s expected %0h actual %0h", testNames[checkedCount],
                         expColors[checkedCount], pixOutColor);
                errorCount++;
            end
            checkedCount++;
        end
    end

endmodule

`default_nettype wire

/* verification/spriteEngineTb.sv */
// Sprite engine testbench
// Replays host writes and pixel requests from the test file, with
// random idle gaps between pixels and random output back-pressure
`timescale 1ns/10ps
`default_nettype none

module spriteEngineTb;

    localparam int ClkPeriod = 40;
    localparam int WaitLimit = 100;   // Cycles allowed for any single wait

    logic                                Clk;
    logic                                rstN;
    logic                                hostValid;
    logic [spritePkg::hostAddrWidth-1:0] hostAddr;
    logic [spritePkg::regWordWidth-1:0]  hostData;
    logic                                hostReady;
    logic                                pixValid;
    logic [spritePkg::coordWidth-1:0]    pixX;
    logic [spritePkg::coordWidth-1:0]    pixY;
    logic                                pixReady;
    logic                                pixOutValid;
    logic [spritePkg::colorWidth-1:0]    pixOutColor;
    logic                                pixOutReady;
    int                                  checkedCount;
    int                                  checkErrors;
    int                                  testCount;
    int                                  stimErrors;
    int                                  sentCount;
    int                                  cycleCount;
    logic                                stall [256];   // Back-pressure pattern
    int                                  gap [64];      // Idle cycles after each pixel

    spriteEngine #(.NumSlots(4)) dut (
        .Clk, .rstN, .hostValid, .hostAddr, .hostData, .hostReady,
        .pixValid, .pixX, .pixY, .pixReady, .pixOutValid, .pixOutColor, .pixOutReady
    );

    spriteChecker respCheck (
        .Clk, .rstN, .pixOutValid, .pixOutColor, .pixOutReady,
        .checkedCount, .errorCount(checkErrors), .testCount
    );

    initial begin
        Clk = 1'b0;
        forever #(ClkPeriod / 2) Clk = ~Clk;
    end

    always @(negedge Clk) begin
        pixOutReady = !stall[cycleCount % 256];
        cycleCount  = cycleCount + 1;
    end

    //----------------------------------------------------------------------
    // Stimulus tasks, all called on a falling edge
    //----------------------------------------------------------------------
    task automatic waitPixIdle();
        int cycles;
        cycles = 0;
        while (!pixReady && cycles < WaitLimit) begin
            @(negedge Clk);
            cycles++;
        end
        if (!pixReady) begin
            $display("Timed out waiting for pixReady");
            stimErrors++;
        end
    endtask

    task automatic hostWrite(input logic [spritePkg::hostAddrWidth-1:0] addr,
                             input logic [spritePkg::regWordWidth-1:0] data);
        int cycles;
        cycles = 0;
        waitPixIdle();   // No register writes with a pixel in flight
        hostValid = 1'b1;
        hostAddr  = addr;
        hostData  = data;
        #1;
        while (!hostReady && cycles < WaitLimit) begin
            @(negedge Clk);
            cycles++;
        end
        if (!hostReady) begin
            $display("Timed out waiting for hostReady on address %h", addr);
            stimErrors++;
        end
        @(negedge Clk);   // Write lands on the rising edge in between
        hostValid = 1'b0;
    endtask

    task automatic sendPixel(input int x, input int y);
        waitPixIdle();
        pixValid = 1'b1;
        pixX     = x[spritePkg::coordWidth-1:0];
        pixY     = y[spritePkg::coordWidth-1:0];
        @(negedge Clk);
        pixValid = 1'b0;
        repeat (gap[sentCount % 64]) @(negedge Clk);
        sentCount++;
    endtask

    //----------------------------------------------------------------------
    // Main sequence
    //----------------------------------------------------------------------
    initial begin
        int                                  fd;
        int                                  code;
        int                                  cycles;
        int                                  x;
        int                                  y;
        string                               line;
        string                               testName;
        logic [spritePkg::hostAddrWidth-1:0] addr;
        logic [spritePkg::regWordWidth-1:0]  data;
        rstN        = 1'b0;
        hostValid   = 1'b0;
        hostAddr    = '0;
        hostData    = '0;
        pixValid    = 1'b0;
        pixX        = '0;
        pixY        = '0;
        pixOutReady = 1'b0;
        stimErrors  = 0;
        sentCount   = 0;
        cycleCount  = 0;
        void'($urandom(95929));
        for (int i = 0; i < 256; i++) stall[i] = ($urandom % 3) == 0;
        for (int i = 0; i < 64; i++) gap[i] = $urandom % 4;
        repeat (8) @(negedge Clk);
        rstN = 1'b1;

        fd = $fopen("verification/spriteTests.txt", "r");
        if (fd == 0) begin
            $display("Testbench cannot open the test file");
            stimErrors++;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0 && line.getc(0) == "W") begin
                    code = $sscanf(line, "W %h %h", addr, data);
                    hostWrite(addr, data);
                end else if (code > 0 && line.getc(0) == "P") begin
                    code = $sscanf(line, "P %s %d %d", testName, x, y);
                    sendPixel(x, y);
                end
            end
            $fclose(fd);
        end

        cycles = 0;
        while (checkedCount < testCount && cycles < WaitLimit) begin
            @(negedge Clk);
            cycles++;
        end
        if (checkedCount < testCount) begin
            $display("Timed out waiting for the remaining pixel responses");
            stimErrors++;
        end
        $display("Responses checked %0d of %0d, mismatches %0d, other errors %0d",
                 checkedCount, testCount, checkErrors, stimErrors);
        if (checkErrors + stimErrors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
src/spritePkg.sv
src/spriteMemory.sv
src/spriteLayer.sv
src/fetchArbiter.sv
src/hostPort.sv
src/pixelCompositor.sv
src/spriteEngine.sv
verification/spriteChecker.sv
verification/spriteEngineTb.sv

/* Bender.yml */
package:
  name: sprite_engine

sources:
  - src/spritePkg.sv
  - src/spriteMemory.sv
  - src/spriteLayer.sv
  - src/fetchArbiter.sv
  - src/hostPort.sv
  - src/pixelCompositor.sv
  - src/spriteEngine.sv
  - target: test
    files:
      - verification/spriteChecker.sv
      - verification/spriteEngineTb.sv

/* verification/spriteTests.txt */
# W <host address hex> <data hex>   host write, address bit 12 selects the sheet
# P <name> <x dec> <y dec> <expected colour hex>   pixel request
P resetBlank 5 5 0
W 0010 00000003
P background 100 100 3
W 1100 00000001
W 1101 00000002
W 1104 00000005
W 1105 00000000
W 0000 10008208
W 0001 0A140001
P slotOrigin 10 20 1
P slotCol1 11 20 2
P slotRow1 10 21 5
P slotClear 11 21 3
P pastRight 12 20 3
P pastBottom 10 22 3
P beforeLeft 9 20 3
W 0000 10008209
P mirrorCol0 10 20 2
P mirrorCol1 11 20 1
P mirrorRow1 11 21 5
W 0000 10008208
W 1200 00000007
W 1201 00000008
W 1202 00000009
W 1203 0000000A
W 0002 20008204
W 0003 0B140001
P overlapLow 11 20 2
P overlapShow 11 21 9
P slot1Only 12 20 8
P slot1Corner 12 21 A
W 0004 10008208
W 0005 32320000
P disabledSlot 50 50 3
W 1100 0000000C
P newColor 10 20 C
W 1201 0000000D
P newColor1 12 20 D
